/* verilog/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // controller states of the lookup stage
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_LOOKUP = 3'd1,
        ST_MISS   = 3'd2,  // line or uncached request outstanding
        ST_REFILL = 3'd3,  // answer from the return buffer
        ST_CACOP  = 3'd4   // cache op done pulse
    } ctrl_state_e;

    // exception codes, same width as the core's ecode field
    typedef enum logic [5:0] {
        EXC_NONE = 6'h00,
        EXC_ADEF = 6'h08   // fetch address not word aligned
    } exc_e;

    // andi r0, r0, 0 in both slots
    localparam logic [63:0] INST_NOP_PAIR = {2{32'h0340_0000}};

endpackage

/* verilog/icache_bus_pkg.sv */
package icache_bus_pkg;
    import icache_ctrl_pkg::*;

    localparam int LINE_OFFSET_WIDTH = 6;  // 64-byte line

    typedef logic [511:0] line_t;
    typedef logic [63:0]  dword_t;   // two instructions per fetch

    // cache op codes; store-tag shares the index-invalidate encoding path
    typedef enum logic [1:0] {
        CACOP_INDEX_INV = 2'b01,
        CACOP_HIT_INV   = 2'b10
    } cacop_e;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncache;
        logic        cacop_en;
        cacop_e      cacop_code;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] pc;
        dword_t      data;
        exc_e        exc;
    } fetch_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;    // beats minus one
    } mem_req_t;

endpackage

/* verilog/icache_req_stage.sv */
module icache_req_stage
    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_accept,
    input  fetch_req_t             i_req,
    output fetch_req_t             o_buf_req,
    output exc_e                   o_buf_exc,
    output logic [INDEX_WIDTH-1:0] o_rd_index
);

    fetch_req_t req_q;
    exc_e       exc_q;
    logic       misaligned;

    // a cache op carries a set/way address, never checked for alignment
    assign misaligned = !i_req.cacop_en && (i_req.addr[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q <= '0;
            exc_q <= EXC_NONE;
        end else if (i_accept) begin
            req_q <= i_req;
            exc_q <= misaligned ? EXC_ADEF : EXC_NONE;
        end
    end

    // new index while accepting, otherwise hold the buffered set
    // so the array keeps reading the line under lookup
    always_comb begin
        if (i_accept) begin
            o_rd_index = i_req.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
        end else begin
            o_rd_index = req_q.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
        end
    end

    assign o_buf_req = req_q;
    assign o_buf_exc = exc_q;

endmodule

/* verilog/icache_way_arrays.sv */
module icache_way_arrays
    import icache_bus_pkg::*;
#(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = 32 - LINE_OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [INDEX_WIDTH-1:0]      i_rd_index,
    input  logic [INDEX_WIDTH-1:0]      i_wr_index,
    input  logic [1:0]                  i_way_we,
    input  logic                        i_clear,    // invalidate instead of fill
    input  logic [TAG_WIDTH-1:0]        i_wr_tag,
    input  line_t                       i_wr_line,
    output logic [1:0][TAG_WIDTH-1:0]   o_tag,
    output logic [1:0]                  o_valid,
    output line_t [1:0]                 o_line
);

    localparam int SET_NUM = 1 << INDEX_WIDTH;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [TAG_WIDTH-1:0] tag_mem [SET_NUM];
        line_t                line_mem [SET_NUM];
        logic [SET_NUM-1:0]   valid_q;
        logic [TAG_WIDTH-1:0] rd_tag;
        line_t                rd_line;
        logic                 rd_valid;

        // tag and data rams, synchronous read
        always_ff @(posedge clk) begin
            if (i_way_we[w] && !i_clear) begin
                tag_mem[i_wr_index]  <= i_wr_tag;
                line_mem[i_wr_index] <= i_wr_line;
            end
            rd_tag  <= tag_mem[i_rd_index];
            rd_line <= line_mem[i_rd_index];
        end

        // valid bits live in flops so they come up clear
        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_q  <= '0;
                rd_valid <= 1'b0;
            end else begin
                if (i_way_we[w]) begin
                    valid_q[i_wr_index] <= !i_clear;
                end
                rd_valid <= valid_q[i_rd_index];
            end
        end

        assign o_tag[w]   = rd_tag;
        assign o_line[w]  = rd_line;
        assign o_valid[w] = rd_valid;
    end

endmodule

/* verilog/icache_lookup_ctrl.sv */
module icache_lookup_ctrl
    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;
#(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = 32 - LINE_OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_rvalid,
    input  fetch_req_t                i_buf_req,
    input  exc_e                      i_buf_exc,
    input  logic [1:0][TAG_WIDTH-1:0] i_tag,
    input  logic [1:0]                i_valid,
    input  line_t [1:0]               i_line,
    output logic                      o_ready,
    output logic                      o_accept,
    output logic                      o_resp_valid,
    output fetch_resp_t               o_resp,
    output logic                      o_cacop_done,
    output logic [INDEX_WIDTH-1:0]    o_wr_index,
    output logic [1:0]                o_way_we,
    output logic                      o_clear,
    output logic [TAG_WIDTH-1:0]      o_wr_tag,
    output line_t                     o_wr_line,
    output logic                      o_mem_rvalid,
    output mem_req_t                  o_mem_req,
    input  logic                      i_mem_rready,
    input  line_t                     i_mem_rdata
);

    localparam int SET_NUM = 1 << INDEX_WIDTH;

    ctrl_state_e            state_q;
    ctrl_state_e            state_d;
    logic [SET_NUM-1:0]     lru;        // way used last, per set
    line_t                  ret_buf;
    line_t                  line_src;
    dword_t                 resp_data;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic [1:0]             hit;
    logic                   hit_way;
    logic                   victim;
    logic [1:0]             cop_we;
    logic                   lookup_exc;
    logic                   lookup_hit;
    logic                   lookup_cop;
    logic                   fill;

    assign idx = i_buf_req.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag = i_buf_req.addr[31 -: TAG_WIDTH];

    // tag compare on the registered array outputs
    assign hit[0]  = i_valid[0] && (i_tag[0] == tag);
    assign hit[1]  = i_valid[1] && (i_tag[1] == tag);
    assign hit_way = !hit[0];
    assign victim  = !lru[idx];

    assign lookup_exc = (state_q == ST_LOOKUP) && (i_buf_exc != EXC_NONE);
    assign lookup_cop = (state_q == ST_LOOKUP) && !lookup_exc && i_buf_req.cacop_en;
    assign lookup_hit = (state_q == ST_LOOKUP) && !lookup_exc && !i_buf_req.cacop_en
                        && !i_buf_req.uncache && (hit != 2'b00);
    assign fill = (state_q == ST_MISS) && i_mem_rready && !i_buf_req.uncache;

    // index-invalidate picks the way from addr[0], hit-invalidate the hit way
    always_comb begin
        if (i_buf_req.cacop_code == CACOP_HIT_INV) begin
            cop_we = hit;
        end else begin
            cop_we = i_buf_req.addr[0] ? 2'b10 : 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_rvalid) state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (lookup_exc || lookup_hit) begin
                    state_d = i_rvalid ? ST_LOOKUP : ST_IDLE;
                end else if (lookup_cop) begin
                    state_d = ST_CACOP;
                end else begin
                    state_d = ST_MISS;  // miss or uncached
                end
            end
            ST_MISS: begin
                if (i_mem_rready) state_d = ST_REFILL;
            end
            ST_REFILL, ST_CACOP: begin
                state_d = i_rvalid ? ST_LOOKUP : ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (lookup_hit) begin
            lru[idx] <= hit_way;
        end else if (fill) begin
            lru[idx] <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_MISS && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // arrays are written at the rready edge so a lookup accepted
    // during refill already sees the new line
    always_comb begin
        o_way_we = 2'b00;
        o_clear  = 1'b0;
        if (lookup_cop) begin
            o_way_we = cop_we;
            o_clear  = 1'b1;
        end else if (fill) begin
            o_way_we = victim ? 2'b10 : 2'b01;
        end
    end

    assign o_wr_index = idx;
    assign o_wr_tag   = tag;
    assign o_wr_line  = i_mem_rdata;

    // memory request held for the whole miss
    assign o_mem_rvalid = (state_q == ST_MISS);
    always_comb begin
        if (i_buf_req.uncache) begin
            o_mem_req.addr = {i_buf_req.addr[31:3], 3'b000};
            o_mem_req.len  = 8'd1;
        end else begin
            o_mem_req.addr = {i_buf_req.addr[31:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};
            o_mem_req.len  = 8'd15;
        end
    end

    always_comb begin
        line_src = (state_q == ST_REFILL) ? ret_buf : i_line[hit_way];
        if (i_buf_exc == EXC_ADEF) begin
            resp_data = INST_NOP_PAIR;
        end else if (i_buf_req.uncache) begin
            resp_data = ret_buf[63:0];  // uncached data sits in the low dword
        end else begin
            resp_data = line_src[{i_buf_req.addr[5:3], 6'd0} +: 64];
        end
    end

    assign o_resp.pc   = i_buf_req.addr;
    assign o_resp.data = resp_data;
    assign o_resp.exc  = i_buf_exc;

    assign o_resp_valid = lookup_exc || lookup_hit || (state_q == ST_REFILL);
    assign o_cacop_done = (state_q == ST_CACOP);
    assign o_ready      = (state_q == ST_IDLE) || o_resp_valid || o_cacop_done;
    assign o_accept     = o_ready && i_rvalid;

endmodule

/* verilog/icache_top.sv */
module icache_top
    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;
#(
    parameter int INDEX_WIDTH = 6   // 64 sets
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_rvalid,
    input  fetch_req_t  i_req,
    output logic        o_ready,
    output logic        o_resp_valid,
    output fetch_resp_t o_resp,
    output logic        o_cacop_done,
    output logic        o_mem_rvalid,
    output mem_req_t    o_mem_req,
    input  logic        i_mem_rready,
    input  line_t       i_mem_rdata
);

    localparam int TAG_WIDTH = 32 - LINE_OFFSET_WIDTH - INDEX_WIDTH;

    logic                      accept;
    fetch_req_t                buf_req;
    exc_e                      buf_exc;
    logic [INDEX_WIDTH-1:0]    rd_index;
    logic [INDEX_WIDTH-1:0]    wr_index;
    logic [1:0][TAG_WIDTH-1:0] way_tag;
    logic [1:0]                way_valid;
    line_t [1:0]               way_line;
    logic [1:0]                way_we;
    logic                      clear;
    logic [TAG_WIDTH-1:0]      wr_tag;
    line_t                     wr_line;

    icache_req_stage #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) icache_req_stage_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_accept   (accept),
        .i_req      (i_req),
        .o_buf_req  (buf_req),
        .o_buf_exc  (buf_exc),
        .o_rd_index (rd_index)
    );

    icache_way_arrays #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) icache_way_arrays_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_way_we   (way_we),
        .i_clear    (clear),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line),
        .o_tag      (way_tag),
        .o_valid    (way_valid),
        .o_line     (way_line)
    );

    icache_lookup_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) icache_lookup_ctrl_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_buf_req    (buf_req),
        .i_buf_exc    (buf_exc),
        .i_tag        (way_tag),
        .i_valid      (way_valid),
        .i_line       (way_line),
        .o_ready      (o_ready),
        .o_accept     (accept),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_cacop_done (o_cacop_done),
        .o_wr_index   (wr_index),
        .o_way_we     (way_we),
        .o_clear      (clear),
        .o_wr_tag     (wr_tag),
        .o_wr_line    (wr_line),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_req    (o_mem_req),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata)
    );

endmodule

/* verif/icache_tb_vectors.svh */
`ifndef ICACHE_TB_VECTORS_SVH
`define ICACHE_TB_VECTORS_SVH

// columns: name, op, address, uncache, expected exception,
// new memory requests, expected memory request {addr, len}

typedef enum logic [1:0] {
    OP_FETCH,
    OP_IDX_INV,   // way picked by addr[0]
    OP_HIT_INV
} op_e;

typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic        uncache;
    exc_e        exp_exc;
    int          exp_count;
    mem_req_t    exp_mem;
} vec_t;

localparam mem_req_t NO_MEM = '0;

string vec_name[$];
vec_t  vec_q[$];

task automatic add_vec(input string name, input op_e op, input logic [31:0] addr,
                       input logic unc, input exc_e exc, input int cnt,
                       input mem_req_t mreq);
    vec_t v;
    v.op        = op;
    v.addr      = addr;
    v.uncache   = unc;
    v.exp_exc   = exc;
    v.exp_count = cnt;
    v.exp_mem   = mreq;
    vec_name.push_back(name);
    vec_q.push_back(v);
endtask

// set 0 holds line 0x4000; lines A 0x1040, B 0x2040 and C 0x3040 share set 1
task automatic load_vectors();
    add_vec("cold_miss",     OP_FETCH, 32'h4008, 1'b0, EXC_NONE, 1, {32'h4000, 8'd15});
    add_vec("hit_same_line", OP_FETCH, 32'h4030, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("fill_a",        OP_FETCH, 32'h1040, 1'b0, EXC_NONE, 1, {32'h1040, 8'd15});
    add_vec("fill_b",        OP_FETCH, 32'h2048, 1'b0, EXC_NONE, 1, {32'h2040, 8'd15});
    add_vec("touch_a",       OP_FETCH, 32'h1050, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("fill_c",        OP_FETCH, 32'h3040, 1'b0, EXC_NONE, 1, {32'h3040, 8'd15});
    add_vec("refetch_a",     OP_FETCH, 32'h1058, 1'b0, EXC_NONE, 0, NO_MEM);  // a was touched
    add_vec("refetch_b",     OP_FETCH, 32'h2040, 1'b0, EXC_NONE, 1, {32'h2040, 8'd15});
    add_vec("uncached_1",    OP_FETCH, 32'h8014, 1'b1, EXC_NONE, 1, {32'h8010, 8'd1});
    add_vec("uncached_2",    OP_FETCH, 32'h8014, 1'b1, EXC_NONE, 1, {32'h8010, 8'd1});
    add_vec("misaligned",    OP_FETCH, 32'h4002, 1'b0, EXC_ADEF, 0, NO_MEM);
    add_vec("idx_inv_way0",  OP_IDX_INV, 32'h4000, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("idx_inv_way1",  OP_IDX_INV, 32'h4001, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("refill_set0",   OP_FETCH, 32'h4008, 1'b0, EXC_NONE, 1, {32'h4000, 8'd15});
    add_vec("hit_inv_b",     OP_HIT_INV, 32'h2040, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("a_resident",    OP_FETCH, 32'h1040, 1'b0, EXC_NONE, 0, NO_MEM);
    add_vec("refill_b",      OP_FETCH, 32'h2068, 1'b0, EXC_NONE, 1, {32'h2040, 8'd15});
endtask

`endif

/* verif/icache_tb.sv */
module icache_tb
    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     TIMEOUT  = 200;
    localparam dword_t NOP_PAIR = 64'h0340_0000_0340_0000;  // two andi r0,r0,0

    logic        clk;
    logic        rstn;
    logic        i_rvalid;
    fetch_req_t  i_req;
    logic        o_ready;
    logic        o_resp_valid;
    fetch_resp_t o_resp;
    logic        o_cacop_done;
    logic        o_mem_rvalid;
    mem_req_t    o_mem_req;
    logic        i_mem_rready;
    line_t       i_mem_rdata;

    int       mem_count;      // requests answered so far
    mem_req_t last_mem_req;
    int       error_count;
    int       test_count;
    int       failed_tests;

    `include "icache_tb_vectors.svh"

    icache_top #(
        .INDEX_WIDTH (6)
    ) icache_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_req        (i_req),
        .o_ready      (o_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_cacop_done (o_cacop_done),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_req    (o_mem_req),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata)
    );

    // dword k of a line is its own address joined with the inverse
    function automatic dword_t pattern_dword(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:3], 3'b000};
        return {a, ~a};
    endfunction

    function automatic line_t pattern_line(input logic [31:0] base);
        line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*64 +: 64] = pattern_dword(base + 32'(k * 8));
        end
        return line;
    endfunction

    task automatic check_resp(input string name, input fetch_resp_t exp, input fetch_resp_t act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected pc=%h data=%h exc=%h actual pc=%h data=%h exc=%h",
                     name, exp.pc, exp.data, exp.exc, act.pc, act.data, act.exc);
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s mem_req: expected addr=%h len=%0d actual addr=%h len=%0d",
                     name, exp.addr, exp.len, act.addr, act.len);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        if (act != exp) begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %0d actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_count++;
        if (error_count == err_before) begin
            $display("PASS %s", name);
        end else begin
            failed_tests++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_vector(input string name, input vec_t v, output bit timed_out);
        fetch_req_t  req;
        fetch_resp_t exp_resp;
        int          count_before;
        int          cyc;
        bit          is_cop;
        timed_out      = 1'b0;
        is_cop         = (v.op != OP_FETCH);
        req.addr       = v.addr;
        req.uncache    = v.uncache;
        req.cacop_en   = is_cop;
        req.cacop_code = (v.op == OP_HIT_INV) ? CACOP_HIT_INV : CACOP_INDEX_INV;
        count_before   = mem_count;
        @(posedge clk);
        #5;
        i_rvalid = 1'b1;
        i_req    = req;
        cyc = 0;
        @(negedge clk);
        while (!o_ready && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!o_ready) begin
            $display("timeout: %s was never accepted by the cache", name);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);  // acceptance edge
        #5;
        i_rvalid = 1'b0;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!(is_cop ? o_cacop_done : o_resp_valid) && cyc < TIMEOUT);
        if (!(is_cop ? o_cacop_done : o_resp_valid)) begin
            $display("timeout: %s got no response within %0d cycles", name, TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        if (is_cop) begin
            check_count(name, "done latency", 2, cyc);
        end else begin
            exp_resp.pc   = v.addr;
            exp_resp.exc  = v.exp_exc;
            exp_resp.data = (v.exp_exc == EXC_ADEF) ? NOP_PAIR : pattern_dword(v.addr);
            check_resp(name, exp_resp, o_resp);
            if (v.exp_count == 0) check_count(name, "response latency", 1, cyc);  // hit or exc
        end
        check_count(name, "memory requests", v.exp_count, mem_count - count_before);
        if (v.exp_count != 0) check_mem_req(name, v.exp_mem, last_mem_req);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory model answering after 1 to 4 cycles
    initial begin
        int unsigned delay;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        mem_count    = 0;
        last_mem_req = '0;
        void'($urandom(32'h6ffe));
        forever begin
            @(negedge clk);
            if (rstn && o_mem_rvalid) begin
                last_mem_req = o_mem_req;
                mem_count++;
                delay = 1 + ($urandom % 4);
                repeat (delay) @(posedge clk);
                #5;
                i_mem_rready = 1'b1;
                i_mem_rdata  = pattern_line(o_mem_req.addr);  // uncached uses dword 0
                @(posedge clk);
                #5;
                i_mem_rready = 1'b0;
            end
        end
    end

    initial begin
        bit timed_out;
        int err_before;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_req        = '0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        load_vectors();
        repeat (8) @(posedge clk);
        #5;
        rstn = 1'b1;
        @(negedge clk);
        err_before = error_count;
        check_flag("reset_state", "o_ready", 1'b1, o_ready);
        check_flag("reset_state", "o_resp_valid", 1'b0, o_resp_valid);
        check_flag("reset_state", "o_cacop_done", 1'b0, o_cacop_done);
        check_flag("reset_state", "o_mem_rvalid", 1'b0, o_mem_rvalid);
        report_test("reset_state", err_before);
        for (int i = 0; i < vec_q.size() && !timed_out; i++) begin
            err_before = error_count;
            run_vector(vec_name[i], vec_q[i], timed_out);
            if (timed_out) error_count++;
            report_test(vec_name[i], err_before);
        end
        $display("tests: %0d  passed: %0d  failed: %0d  errors: %0d",
                 test_count, test_count - failed_tests, failed_tests, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
verilog/icache_ctrl_pkg.sv
verilog/icache_bus_pkg.sv
verilog/icache_req_stage.sv
verilog/icache_way_arrays.sv
verilog/icache_lookup_ctrl.sv
verilog/icache_top.sv
verif/icache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation result: FAIL"; exit 1; \
	else \
		echo "simulation result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
